/* logic/fetch_pkg.sv */
package fetch_pkg;

	// ******************************************************************
	// widths and reset
	// ******************************************************************
	localparam int xlen = 64;
	localparam int ilen = 32;
	// first fetch address out of reset
	localparam logic [xlen-1:0] reset_vector = 64'h8000_0000;

	// icache geometry, one 64-bit word per line
	localparam int icache_lines = 16;
	localparam int icache_index_bits = $clog2(icache_lines);
	// what is left above index and byte offset
	localparam int icache_tag_bits = xlen - icache_index_bits - 3;

	// refill sequencer states
	localparam logic [1:0] cache_idle = 2'd0;
	localparam logic [1:0] cache_refill = 2'd1;
	localparam logic [1:0] cache_respond = 2'd2;

	// ******************************************************************
	// decode bits the predictor looks at
	// ******************************************************************
	localparam logic [6:0] opcode_jal = 7'b1101111;
	localparam logic [6:0] opcode_branch = 7'b1100011;
	// legal branch funct3 codes
	localparam logic [2:0] f3_beq = 3'b000;
	localparam logic [2:0] f3_bne = 3'b001;
	localparam logic [2:0] f3_blt = 3'b100;
	localparam logic [2:0] f3_bge = 3'b101;
	localparam logic [2:0] f3_bltu = 3'b110;
	localparam logic [2:0] f3_bgeu = 3'b111;

	// owner of the shared memory
	typedef enum logic {
		src_cache = 1'b0,
		src_load = 1'b1
	} mem_req_src;

	// one instruction word, seen as B-type or J-type
	typedef union packed {
		struct packed {
			logic       sign;
			logic [5:0] imm10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm4_1;
			logic       imm11;
			logic [6:0] opcode;
		} b_view;
		struct packed {
			logic       sign;
			logic [9:0] imm10_1;
			logic       imm11;
			logic [7:0] imm19_12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} j_view;
	} inst_word_u;

endpackage

/* logic/fetch_unit.sv */
`timescale 1ns/10ps

module fetch_unit
	import fetch_pkg::*;
(
	input  logic            clk,
	input  logic            rst,
	input  logic            redirect,
	input  logic [xlen-1:0] redirect_pc,
	input  logic            id_ready,
	output logic            if_valid,
	output logic [ilen-1:0] if_inst,
	output logic [xlen-1:0] if_pc,
	output logic            fetch_req,
	output logic [xlen-1:0] fetch_addr,
	input  logic            fetch_ready,
	output logic            fetch_flush,
	input  logic            inst_valid,
	input  logic [ilen-1:0] inst
);

	// address of the next request
	logic [xlen-1:0] pc;
	// pc and stale mark of the request in flight
	logic [xlen-1:0] fl_pc;
	logic            fl_stale;
	// one spare entry behind the output stage
	logic            sk_valid;
	logic [ilen-1:0] sk_inst;
	logic [xlen-1:0] sk_pc;

	inst_word_u      iw;
	logic            is_jal;
	logic            is_branch;
	logic            res_ok;
	logic            take;
	logic            stage_free;
	logic            accept;
	logic [xlen-1:0] imm_b;
	logic [xlen-1:0] imm_j;
	logic [xlen-1:0] target;

	// ******************************************************************
	// static prediction on the returned word
	// ******************************************************************
	assign iw = inst;
	assign is_jal = (iw.j_view.opcode == opcode_jal);
	assign is_branch = (iw.b_view.opcode == opcode_branch) &&
		(iw.b_view.funct3 inside {f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu});

	// B immediate, 13 bits sign extended
	assign imm_b = {{(xlen-13){iw.b_view.sign}}, iw.b_view.sign, iw.b_view.imm11,
		iw.b_view.imm10_5, iw.b_view.imm4_1, 1'b0};
	// J immediate, 21 bits sign extended
	assign imm_j = {{(xlen-21){iw.j_view.sign}}, iw.j_view.sign, iw.j_view.imm19_12,
		iw.j_view.imm11, iw.j_view.imm10_1, 1'b0};

	// a result counts only if not stale and not flushed this cycle
	assign res_ok = inst_valid && !fl_stale && !redirect;
	// jal always, branch only when backward
	assign take = res_ok && (is_jal || (is_branch && iw.b_view.sign));
	assign target = fl_pc + (is_jal ? imm_j : imm_b);

	// ******************************************************************
	// request side
	// ******************************************************************
	assign stage_free = !if_valid || id_ready;
	// stop asking once the stage is stuck or the spare is used
	assign fetch_req = !redirect && !sk_valid && stage_free;
	assign fetch_addr = pc;
	assign fetch_flush = redirect;
	assign accept = fetch_req && fetch_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= reset_vector;
			fl_stale <= 1'b0;
			if_valid <= 1'b0;
			sk_valid <= 1'b0;
		end else begin
			// redirect beats prediction beats fall-through
			if (redirect)
				pc <= redirect_pc;
			else if (take)
				pc <= target;
			else if (accept)
				pc <= pc + xlen'(4);
			// request issued alongside a taken prediction is dead
			if (accept)
				fl_stale <= take;
			// output stage and spare
			if (redirect) begin
				if_valid <= 1'b0;
				sk_valid <= 1'b0;
			end else if (stage_free) begin
				if (sk_valid) begin
					if_valid <= 1'b1;
					sk_valid <= 1'b0;
				end else begin
					if_valid <= res_ok;
				end
			end else if (res_ok) begin
				sk_valid <= 1'b1;
			end
		end
	end

	// payload
	always_ff @(posedge clk) begin
		if (accept)
			fl_pc <= pc;
		if (stage_free) begin
			if (sk_valid) begin
				if_inst <= sk_inst;
				if_pc <= sk_pc;
			end else if (res_ok) begin
				if_inst <= inst;
				if_pc <= fl_pc;
			end
		end else if (res_ok) begin
			// stage held by decode, park the word
			sk_inst <= inst;
			sk_pc <= fl_pc;
		end
	end

endmodule

/* logic/inst_cache.sv */
`timescale 1ns/10ps

module inst_cache
	import fetch_pkg::*;
(
	input  logic            clk,
	input  logic            rst,
	input  logic            fetch_req,
	input  logic [xlen-1:0] fetch_addr,
	output logic            fetch_ready,
	input  logic            fetch_flush,
	output logic            inst_valid,
	output logic [ilen-1:0] inst,
	output logic            refill_req,
	output logic [xlen-1:0] refill_addr,
	input  logic            refill_ack,
	input  logic [xlen-1:0] refill_data
);

	// ******************************************************************
	// storage
	// ******************************************************************
	logic [icache_tag_bits-1:0] tag_mem [icache_lines];
	logic [xlen-1:0]            data_mem [icache_lines];
	logic [icache_lines-1:0]    line_valid;

	logic [1:0]                   state;
	// set when the pending miss result must not come back
	logic                         drop;
	logic [xlen-1:0]              req_addr;
	logic [icache_index_bits-1:0] idx;
	logic [icache_index_bits-1:0] req_idx;
	logic                         accept;
	logic                         hit;
	logic [xlen-1:0]              rd_word;
	logic                         rd_half;

	// index sits right above the byte offset
	assign idx = fetch_addr[3 +: icache_index_bits];
	assign req_idx = req_addr[3 +: icache_index_bits];

	assign fetch_ready = (state == cache_idle);
	assign accept = fetch_req && fetch_ready && !fetch_flush;
	assign hit = line_valid[idx] &&
		(tag_mem[idx] == fetch_addr[xlen-1 -: icache_tag_bits]);

	// memory side, aligned word address
	assign refill_req = (state == cache_refill);
	assign refill_addr = {req_addr[xlen-1:3], 3'b000};

	// word to answer from, hit path or refilled line
	assign rd_word = (state == cache_respond) ? data_mem[req_idx] : data_mem[idx];
	assign rd_half = (state == cache_respond) ? req_addr[2] : fetch_addr[2];

	// ******************************************************************
	// hit path and refill sequencer
	// ******************************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= cache_idle;
			line_valid <= '0;
			inst_valid <= 1'b0;
			drop <= 1'b0;
		end else begin
			inst_valid <= 1'b0;
			case (state)
				cache_idle: begin
					if (accept && hit) begin
						inst_valid <= 1'b1;
					end else if (accept) begin
						state <= cache_refill;
						drop <= 1'b0;
					end
				end
				cache_refill: begin
					if (refill_ack) begin
						state <= cache_respond;
						line_valid[req_idx] <= 1'b1;
					end
				end
				cache_respond: begin
					state <= cache_idle;
					// line stays filled even if the answer is dropped
					inst_valid <= !(drop || fetch_flush);
				end
				default: begin
					state <= cache_idle;
				end
			endcase
			if (fetch_flush)
				drop <= 1'b1;
		end
	end

	// arrays and result word
	always_ff @(posedge clk) begin
		if (accept)
			req_addr <= fetch_addr;
		if (state == cache_refill && refill_ack) begin
			tag_mem[req_idx] <= req_addr[xlen-1 -: icache_tag_bits];
			data_mem[req_idx] <= refill_data;
		end
		// address bit 2 picks the half
		if ((accept && hit) || state == cache_respond)
			inst <= rd_half ? rd_word[63:32] : rd_word[31:0];
	end

endmodule

/* logic/load_port.sv */
`timescale 1ns/10ps

module load_port
	import fetch_pkg::*;
(
	input  logic            clk,
	input  logic            rst,
	input  logic            load_req,
	input  logic [xlen-1:0] load_addr,
	output logic            load_busy,
	output logic            load_done,
	output logic [xlen-1:0] load_data,
	output logic            rd_req,
	output logic [xlen-1:0] rd_addr,
	input  logic            rd_ack,
	input  logic [xlen-1:0] rd_data
);

	// address of the read in progress
	logic [xlen-1:0] addr_q;

	// request level held for the whole read
	assign rd_req = load_busy;
	assign rd_addr = {addr_q[xlen-1:3], 3'b000};

	always_ff @(posedge clk) begin
		if (rst) begin
			load_busy <= 1'b0;
			load_done <= 1'b0;
		end else begin
			load_done <= 1'b0;
			if (!load_busy && load_req) begin
				load_busy <= 1'b1;
			end else if (load_busy && rd_ack) begin
				load_busy <= 1'b0;
				load_done <= 1'b1;
			end
		end
	end

	// payload
	always_ff @(posedge clk) begin
		if (!load_busy && load_req)
			addr_q <= load_addr;
		if (load_busy && rd_ack)
			load_data <= rd_data;
	end

endmodule

/* logic/mem_arbiter.sv */
`timescale 1ns/10ps

module mem_arbiter
	import fetch_pkg::*;
(
	input  logic            clk,
	input  logic            rst,
	input  logic            refill_req,
	input  logic [xlen-1:0] refill_addr,
	output logic            refill_ack,
	output logic [xlen-1:0] refill_data,
	input  logic            rd_req,
	input  logic [xlen-1:0] rd_addr,
	output logic            rd_ack,
	output logic [xlen-1:0] rd_data,
	output logic            mem_req,
	output logic [xlen-1:0] mem_addr,
	input  logic            mem_ack,
	input  logic [xlen-1:0] mem_rdata
);

	// owner while a request is open
	mem_req_src grant;
	logic       busy;
	// owner this cycle
	mem_req_src sel;

	// locked grant, else cache first
	always_comb begin
		if (busy)
			sel = grant;
		else if (refill_req)
			sel = src_cache;
		else
			sel = src_load;
	end

	assign mem_req = (sel == src_cache) ? refill_req : rd_req;
	assign mem_addr = (sel == src_cache) ? refill_addr : rd_addr;

	// ack goes only to the owner
	assign refill_ack = mem_ack && (sel == src_cache);
	assign rd_ack = mem_ack && (sel == src_load);
	assign refill_data = mem_rdata;
	assign rd_data = mem_rdata;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			grant <= src_cache;
		end else begin
			// open from acceptance until the ack
			busy <= mem_req && !mem_ack;
			grant <= sel;
		end
	end

endmodule

/* logic/fetch_top.sv */
`timescale 1ns/10ps

module fetch_top
	import fetch_pkg::*;
(
	input  logic            clk,
	input  logic            rst,
	// decode and redirect
	input  logic            redirect,
	input  logic [xlen-1:0] redirect_pc,
	input  logic            id_ready,
	output logic            if_valid,
	output logic [ilen-1:0] if_inst,
	output logic [xlen-1:0] if_pc,
	// uncached loads
	input  logic            load_req,
	input  logic [xlen-1:0] load_addr,
	output logic            load_busy,
	output logic            load_done,
	output logic [xlen-1:0] load_data,
	// shared memory
	output logic            mem_req,
	output logic [xlen-1:0] mem_addr,
	input  logic            mem_ack,
	input  logic [xlen-1:0] mem_rdata
);

	// fetch unit to cache
	logic            fetch_req;
	logic [xlen-1:0] fetch_addr;
	logic            fetch_ready;
	logic            fetch_flush;
	logic            inst_valid;
	logic [ilen-1:0] inst;
	// requesters to arbiter
	logic            refill_req;
	logic [xlen-1:0] refill_addr;
	logic            refill_ack;
	logic [xlen-1:0] refill_data;
	logic            rd_req;
	logic [xlen-1:0] rd_addr;
	logic            rd_ack;
	logic [xlen-1:0] rd_data;

	// ******************************************************************
	// port names match the nets above
	// ******************************************************************
	fetch_unit fetch_unit_i (.*);
	inst_cache inst_cache_i (.*);
	load_port load_port_i (.*);
	mem_arbiter mem_arbiter_i (.*);

endmodule

/* verif/fetch_checker.sv */
`timescale 1ns/10ps

module fetch_checker
	import fetch_pkg::*;
(
	input logic            clk,
	input logic            rst,
	input logic            redirect,
	input logic            id_ready,
	input logic            if_valid,
	input logic [ilen-1:0] if_inst,
	input logic [xlen-1:0] if_pc,
	input logic            mem_req,
	input logic            mem_ack,
	input logic [xlen-1:0] mem_addr
);

	// assertion failures so far
	int unsigned fail_count = 0;

	// stage held while decode stalls unless flushed
	stage_hold: assert property (@(posedge clk) disable iff (rst)
		if_valid && !id_ready && !redirect |=>
			if_valid && $stable(if_inst) && $stable(if_pc))
		else begin
			fail_count++;
			$error("decode stage changed under back-pressure");
		end

	// open memory request keeps its address
	addr_hold: assert property (@(posedge clk) disable iff (rst)
		mem_req && !mem_ack |=> mem_req && $stable(mem_addr))
		else begin
			fail_count++;
			$error("memory request dropped or address moved before ack");
		end

	// nothing leaves fetch during reset
	quiet_reset: assert property (@(posedge clk) rst && $past(rst) |-> !if_valid)
		else begin
			fail_count++;
			$error("if_valid high during reset");
		end

endmodule

/* verif/fetch_tests.svh */
`ifndef FETCH_TESTS_SVH
`define FETCH_TESTS_SVH

// ******************************************************************
// encoders and the reference pc sequencer
// ******************************************************************
function automatic logic [31:0] enc_jal(input logic [20:0] off);
	return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};
endfunction

function automatic logic [31:0] enc_branch(input logic [2:0] f3, input logic [12:0] off);
	return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], 7'b1100011};
endfunction

// jal taken, backward branch taken, else next word
function automatic logic [63:0] next_pc(input logic [63:0] pc);
	logic [31:0] i;
	logic [63:0] imm_j;
	logic [63:0] imm_b;
	i = mem_half(pc);
	imm_j = {{44{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
	imm_b = {{52{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
	if (i[6:0] == 7'b1101111)
		return pc + imm_j;
	if (i[6:0] == 7'b1100011 && i[14:13] != 2'b01 && i[31])
		return pc + imm_b;
	return pc + 64'd4;
endfunction

task automatic wait_items(input int n);
	int guard;
	guard = 0;
	while (got_pc.size() < n) begin
		@(posedge clk);
		guard++;
		if (guard > n * item_cycles) begin
			$display("fetch stream stalled, %0d of %0d instructions", got_pc.size(), n);
			stop_run();
		end
	end
endtask

// compare the first n accepted instructions against the sequencer
task automatic check_stream(input string name, input logic [63:0] start, input int n);
	logic [63:0] pc;
	wait_items(n);
	pc = start;
	for (int k = 0; k < n; k++) begin
		check_eq({name, " pc"}, pc, got_pc[k]);
		check_eq({name, " inst"}, 64'(mem_half(pc)), 64'(got_inst[k]));
		pc = next_pc(pc);
	end
endtask

// ******************************************************************
// directed tests
// ******************************************************************
task automatic straight_code();
	hold_reset();
	release_reset();
	check_stream("straight", reset_vector, n_straight);
endtask

task automatic jal_skip();
	hold_reset();
	put_half(reset_vector + 64'h08, enc_jal(21'h00040));
	put_half(reset_vector + 64'h4c, enc_jal(21'h1fffc4));
	release_reset();
	check_stream("jal", reset_vector, n_jal);
	// skipped fall-through must never show up
	foreach (got_pc[k])
		if (got_pc[k] == reset_vector + 64'h0c) begin
			$display("fall-through after jal was delivered to decode");
			stop_run();
		end
endtask

task automatic branch_loop();
	hold_reset();
	// forward beq falls through, backward bne closes a 5 word loop
	put_half(reset_vector + 64'h04, enc_branch(3'b000, 13'h0020));
	put_half(reset_vector + 64'h10, enc_branch(3'b001, 13'h1ff0));
	release_reset();
	check_stream("loop", reset_vector, n_loop);
endtask

task automatic redirect_to(input logic [63:0] pc);
	@(posedge clk);
	id_ready <= 1'b0;
	@(posedge clk);
	redirect <= 1'b1;
	redirect_pc <= pc;
	@(posedge clk);
	redirect <= 1'b0;
	id_ready <= 1'b1;
	got_pc.delete();
	got_inst.delete();
	check_stream("redirect", pc, n_redirect);
endtask

task automatic redirect_flow();
	hold_reset();
	put_half(reset_vector + 64'h208, enc_jal(21'h00100));
	release_reset();
	// first one lands during the cold miss
	redirect_to(reset_vector + 64'h200);
	redirect_to(reset_vector + 64'h404);
endtask

task automatic decode_stall();
	int v;
	hold_reset();
	release_reset();
	while (got_pc.size() < n_stall) begin
		rand_bits(test_lfsr, 3, v);
		id_ready <= 1'b0;
		repeat (v) @(posedge clk);
		id_ready <= 1'b1;
		rand_bits(test_lfsr, 2, v);
		repeat (v + 1) @(posedge clk);
	end
	id_ready <= 1'b1;
	check_stream("stall", reset_vector, n_stall);
endtask

task automatic loads_with_fetch();
	int v;
	int guard;
	logic [63:0] a;
	hold_reset();
	release_reset();
	for (int k = 0; k < n_loads; k++) begin
		rand_bits(test_lfsr, 8, v);
		a = reset_vector + (64'(v) << 3) + 64'(k);
		while (load_busy)
			@(posedge clk);
		load_req <= 1'b1;
		load_addr <= a;
		@(posedge clk);
		load_req <= 1'b0;
		guard = 0;
		do begin
			@(posedge clk);
			guard++;
			if (guard > 8 * item_cycles) begin
				$display("load to %h never completed", a);
				stop_run();
			end
			// busy covers the whole read and clears with done
			if (load_done)
				check_eq("load busy", 64'd0, 64'(load_busy));
			else
				check_eq("load busy", 64'd1, 64'(load_busy));
		end while (!load_done);
		check_eq("load", mem[a[11:3]], load_data);
	end
	check_stream("mixed", reset_vector, n_mixed);
endtask

`endif

/* verif/fetch_tb.sv */
`timescale 1ns/10ps

module fetch_tb
	import fetch_pkg::*;
();

	// ******************************************************************
	// run lengths that size the watchdog
	// ******************************************************************
	localparam int n_straight = 24;
	localparam int n_jal = 16;
	localparam int n_loop = 15;
	localparam int n_redirect = 12;
	localparam int n_stall = 24;
	localparam int n_loads = 6;
	localparam int n_mixed = 30;
	localparam int item_cycles = 30;
	localparam int n_items = n_straight + n_jal + n_loop + 2 * n_redirect + n_stall +
		n_mixed + 8 * n_loads;
	localparam int watchdog_cycles = n_items * item_cycles + 6 * 40;
	localparam int mem_words = 512;

	logic            clk = 1'b0;
	logic            rst;
	logic            redirect;
	logic [xlen-1:0] redirect_pc;
	logic            id_ready;
	logic            if_valid;
	logic [ilen-1:0] if_inst;
	logic [xlen-1:0] if_pc;
	logic            load_req;
	logic [xlen-1:0] load_addr;
	logic            load_busy;
	logic            load_done;
	logic [xlen-1:0] load_data;
	logic            mem_req;
	logic [xlen-1:0] mem_addr;
	logic            mem_ack = 1'b0;
	logic [xlen-1:0] mem_rdata = '0;

	logic [63:0]     mem [mem_words];
	logic [2:0]      wait_cnt = '0;
	logic [31:0]     mem_lfsr = 32'h89db6005;
	logic [31:0]     test_lfsr = 32'h89db6005;
	// accepted decode stream
	logic [63:0]     got_pc [$];
	logic [31:0]     got_inst [$];

	always #10 clk = ~clk;

	fetch_top fetch_top_i (.*);

	bind fetch_top fetch_checker checker_i (.*);

	// ******************************************************************
	// helpers
	// ******************************************************************
	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(inout logic [31:0] s, input int n, output int v);
		v = 0;
		for (int k = 0; k < n; k++) begin
			s = lfsr_step(s);
			v = (v << 1) | int'(s[0]);
		end
	endtask

	task automatic stop_run();
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			stop_run();
		end
	endtask

	// background word keeps the addi opcode so it never redirects
	function automatic logic [31:0] fill_half(input logic [63:0] a);
		logic [31:0] h;
		h = a[63:32] ^ a[31:0] ^ 32'h5a5a_0000;
		return {h[26:2], 7'h13};
	endfunction

	function automatic logic [31:0] mem_half(input logic [63:0] a);
		return a[2] ? mem[a[11:3]][63:32] : mem[a[11:3]][31:0];
	endfunction

	task automatic put_half(input logic [63:0] a, input logic [31:0] v);
		if (a[2])
			mem[a[11:3]][63:32] = v;
		else
			mem[a[11:3]][31:0] = v;
	endtask

	task automatic init_memory();
		logic [63:0] base;
		for (int i = 0; i < mem_words; i++) begin
			base = reset_vector + (64'(i) << 3);
			mem[i] = {fill_half(base + 64'd4), fill_half(base)};
		end
	endtask

	// ******************************************************************
	// memory model acks 1 to 4 cycles after a request
	// ******************************************************************
	always @(posedge clk) begin
		int d;
		mem_ack <= 1'b0;
		if (rst) begin
			wait_cnt <= '0;
		end else if (wait_cnt != 3'd0) begin
			wait_cnt <= wait_cnt - 3'd1;
			if (wait_cnt == 3'd1) begin
				mem_ack <= 1'b1;
				mem_rdata <= mem[mem_addr[11:3]];
			end
		end else if (mem_req && !mem_ack) begin
			rand_bits(mem_lfsr, 2, d);
			wait_cnt <= 3'(d + 1);
		end
	end

	// decode side monitor
	always @(posedge clk) begin
		if (!rst && if_valid && id_ready) begin
			got_pc.push_back(if_pc);
			got_inst.push_back(if_inst);
		end
	end

	// any checker failure ends the run
	always @(fetch_top_i.checker_i.fail_count) begin
		if (fetch_top_i.checker_i.fail_count != 0) begin
			$display("a fetch checker assertion failed");
			stop_run();
		end
	end

	// reset in two halves so a program can be loaded in between
	task automatic hold_reset();
		@(posedge clk);
		rst <= 1'b1;
		redirect <= 1'b0;
		id_ready <= 1'b1;
		load_req <= 1'b0;
		repeat (2) @(posedge clk);
		init_memory();
	endtask

	task automatic release_reset();
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		got_pc.delete();
		got_inst.delete();
	endtask

	`include "fetch_tests.svh"

	initial begin
		#(watchdog_cycles * 20);
		$display("watchdog expired before the tests finished");
		stop_run();
	end

	initial begin
		rst = 1'b1;
		redirect = 1'b0;
		redirect_pc = '0;
		id_ready = 1'b1;
		load_req = 1'b0;
		load_addr = '0;
		init_memory();
		straight_code();
		jal_skip();
		branch_loop();
		redirect_flow();
		decode_stall();
		loads_with_fetch();
		$display("Done: no errors");
		$finish;
	end

endmodule

/* sources.f */
+incdir+verif
logic/fetch_pkg.sv
logic/fetch_unit.sv
logic/inst_cache.sv
logic/load_port.sv
logic/mem_arbiter.sv
logic/fetch_top.sv
verif/fetch_checker.sv
verif/fetch_tb.sv

/* Makefile */
# Verilator build and run for the fetch front end

VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SOURCES   := $(wildcard logic/*.sv verif/*.sv verif/*.svh)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "Done: no errors" $(LOG); then echo "simulation incomplete"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
